// ==== decode_stage2.f ====
source/decode2_pkg.sv
source/field_extract.sv
source/microcode_rom.sv
source/uop_sequencer.sv
source/operand_ctrl.sv
source/decode_stage2.sv
testbench/decode_stage2_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the decode stage 2 testbench with Verilator, run it, look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
   -f decode_stage2.f --top-module decode_stage2_tb -o decode_stage2_sim &&
   ./obj_dir/decode_stage2_sim | tee /dev/stderr | grep -F "Simulation passed" > /dev/null &&
   echo "run_sim: pass" ||
   { echo "run_sim: FAIL"; exit 1; }

// ==== source/decode2_pkg.sv ====
package decode2_pkg;

   // instruction window, byte k sits at bits 8k+7:8k
   typedef logic [127:0] instr_bits_t;
   typedef logic [31:0]  addr32_t;
   // far pointer: selector in 47:32, offset in 31:0
   typedef logic [47:0]  offset48_t;
   typedef logic [7:0]   uaddr_t;
   typedef logic [23:0]  ctrl_word_t;
   typedef logic [2:0]   reg_id_t;
   typedef logic [1:0]   size_t;

   // control word field positions, lsb of each field
   localparam int cw_uop_stall    = 0;
   localparam int cw_next_uaddr   = 1;
   localparam int cw_next_uaddr_w = 7;
   localparam int cw_mux_op_size  = 8;
   localparam int cw_op_size      = 9;
   localparam int cw_mux_sr1      = 11;
   localparam int cw_sr1          = 12;
   localparam int cw_ld_gpr1      = 15;
   localparam int cw_mux_mem_rd   = 16;
   localparam int cw_mem_rd       = 17;
   localparam int cw_mux_aluk     = 18;
   localparam int cw_aluk         = 19;
   localparam int cw_jmp_stall    = 22;
   // bit 23 is spare

   // operand size codes
   localparam size_t size_8  = 2'b00;
   localparam size_t size_16 = 2'b01;
   localparam size_t size_32 = 2'b10;
   localparam size_t size_64 = 2'b11;

   // segment register ids
   localparam reg_id_t seg_es = 3'b000;
   localparam reg_id_t seg_cs = 3'b001;
   localparam reg_id_t seg_ss = 3'b010;
   localparam reg_id_t seg_ds = 3'b011;
   localparam reg_id_t seg_fs = 3'b100;
   localparam reg_id_t seg_gs = 3'b101;

endpackage

// ==== source/decode_stage2.sv ====
`timescale 1ns/10ps

module decode_stage2 #(
   parameter int ir_bytes   = 16,
   parameter int uaddr_bits = 8
) (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        d2_v,
   input  logic                        ld_d2,
   input  logic [ir_bytes*8-1:0]       ir,
   input  decode2_pkg::addr32_t        eip,
   input  logic [15:0]                 cs,
   input  logic [3:0]                  instr_length,
   input  logic [15:0]                 opcode,
   input  logic                        opcode_size,
   input  logic                        operand_override,
   input  logic                        segment_override,
   input  logic                        repeat_prefix,
   input  logic                        modrm_present,
   input  logic                        sib_present,
   input  logic                        disp_present,
   input  logic [$clog2(ir_bytes)-1:0] disp_sel,
   input  logic                        disp_size,
   input  logic [$clog2(ir_bytes)-1:0] imm_sel,
   input  decode2_pkg::size_t          imm_size,
   input  logic [$clog2(ir_bytes)-1:0] off_sel,
   input  logic [1:0]                  offset_size,
   input  decode2_pkg::reg_id_t        seg_id,
   input  logic [7:0]                  modrm,
   input  logic [7:0]                  sib,
   input  decode2_pkg::uaddr_t         decode_address,
   input  logic                        nmi_int_en,
   input  logic                        gen_prot_exc_en,
   input  logic                        page_fault_exc_en,
   input  logic                        int_exist,
   input  logic                        repne_terminate,
   output decode2_pkg::addr32_t        eip_out,
   output logic [15:0]                 cs_out,
   output decode2_pkg::ctrl_word_t     control_word,
   output decode2_pkg::uaddr_t         control_address,
   output decode2_pkg::addr32_t        disp32,
   output decode2_pkg::addr32_t        imm32,
   output decode2_pkg::offset48_t      offset,
   output decode2_pkg::size_t          sr1_size,
   output decode2_pkg::size_t          sr2_size,
   output decode2_pkg::size_t          dr1_size,
   output decode2_pkg::size_t          mem_size,
   output decode2_pkg::reg_id_t        sr1,
   output decode2_pkg::reg_id_t        sr2,
   output decode2_pkg::reg_id_t        sr3,
   output decode2_pkg::reg_id_t        sr4,
   output decode2_pkg::reg_id_t        seg1,
   output decode2_pkg::reg_id_t        seg2,
   output logic [2:0]                  aluk,
   output logic                        mem_rd,
   output logic                        ld_gpr1,
   output logic                        base_reg_en,
   output logic                        sib_en,
   output logic                        disp_en,
   output logic [1:0]                  sib_scale,
   output logic                        repne,
   output logic                        uop_stall,
   output logic                        jmp_stall,
   output logic                        exc_v
);
   import decode2_pkg::*;

   logic opsize_sel;
   logic exc_any;

   // offset width comes from the opcode and override inside the extractor
   field_extract #(
      .ir_bytes (ir_bytes)
   ) i_field_extract (
      .ir               (ir),
      .opcode           (opcode),
      .operand_override (operand_override),
      .disp_sel         (disp_sel),
      .disp_size        (disp_size),
      .imm_sel          (imm_sel),
      .imm_size         (imm_size),
      .off_sel          (off_sel),
      .disp32           (disp32),
      .imm32            (imm32),
      .offset           (offset)
   );

   uop_sequencer i_uop_sequencer (
      .clk             (clk),
      .rst_n           (rst_n),
      .d2_v            (d2_v),
      .ld_d2           (ld_d2),
      .uop_stall_cw    (control_word[cw_uop_stall]),
      .next_uaddr      (control_word[cw_next_uaddr +: cw_next_uaddr_w]),
      .int_exist       (int_exist),
      .repne_terminate (repne_terminate),
      .decode_address  (decode_address),
      .opcode_size     (opcode_size),
      .control_address (control_address),
      .opsize_sel      (opsize_sel)
   );

   microcode_rom #(
      .uaddr_bits (uaddr_bits)
   ) i_microcode_rom (
      .control_address (control_address),
      .opsize_sel      (opsize_sel),
      .control_word    (control_word)
   );

   operand_ctrl i_operand_ctrl (
      .clk              (clk),
      .rst_n            (rst_n),
      .control_word     (control_word),
      .opcode           (opcode),
      .operand_override (operand_override),
      .segment_override (segment_override),
      .seg_id           (seg_id),
      .modrm            (modrm),
      .sib              (sib),
      .modrm_present    (modrm_present),
      .sib_present      (sib_present),
      .sr1_size         (sr1_size),
      .sr2_size         (sr2_size),
      .dr1_size         (dr1_size),
      .mem_size         (mem_size),
      .sr1              (sr1),
      .sr2              (sr2),
      .sr3              (sr3),
      .sr4              (sr4),
      .seg1             (seg1),
      .seg2             (seg2),
      .aluk             (aluk),
      .mem_rd           (mem_rd),
      .ld_gpr1          (ld_gpr1),
      .base_reg_en      (base_reg_en),
      .sib_scale        (sib_scale)
   );

   // a faulting instruction keeps its own eip for the handler
   assign exc_any = nmi_int_en || gen_prot_exc_en || page_fault_exc_en;
   assign eip_out = exc_any ? eip : eip + {28'b0, instr_length};
   assign exc_v   = d2_v && exc_any;

   // hold upstream while the second uop runs or a jump resolves
   assign uop_stall = d2_v && control_word[cw_uop_stall] && !(int_exist || repne_terminate);
   assign jmp_stall = d2_v && control_word[cw_jmp_stall];

   assign cs_out  = cs;
   assign repne   = repeat_prefix;
   assign sib_en  = sib_present;
   assign disp_en = disp_present;

endmodule

// ==== source/field_extract.sv ====
`timescale 1ns/10ps

module field_extract #(
   parameter int ir_bytes = 16
) (
   input  logic [ir_bytes*8-1:0]         ir,
   input  logic [15:0]                   opcode,
   input  logic                          operand_override,
   input  logic [$clog2(ir_bytes)-1:0]   disp_sel,
   input  logic                          disp_size,
   input  logic [$clog2(ir_bytes)-1:0]   imm_sel,
   input  decode2_pkg::size_t            imm_size,
   input  logic [$clog2(ir_bytes)-1:0]   off_sel,
   output decode2_pkg::addr32_t          disp32,
   output decode2_pkg::addr32_t          imm32,
   output decode2_pkg::offset48_t        offset
);
   import decode2_pkg::*;

   localparam int ir_bits = ir_bytes * 8;

   logic [2*ir_bits-1:0] ir_dbl;
   logic [2*ir_bits-1:0] disp_win;
   logic [2*ir_bits-1:0] imm_win;
   logic [2*ir_bits-1:0] off_win;
   logic                 far16;

   // window doubled so a field running off the last byte wraps to byte 0
   assign ir_dbl = {ir, ir};

   // little-endian fields start at the low end once shifted down
   assign disp_win = ir_dbl >> (8 * disp_sel);
   assign imm_win  = ir_dbl >> (8 * imm_sel);
   assign off_win  = ir_dbl >> (8 * off_sel);

   assign disp32 = disp_size ? disp_win[31:0] : {{24{disp_win[7]}}, disp_win[7:0]};

   always_comb begin
      case (imm_size)
         size_8:  imm32 = {{24{imm_win[7]}}, imm_win[7:0]};
         size_16: imm32 = {{16{imm_win[15]}}, imm_win[15:0]};
         default: imm32 = imm_win[31:0];
      endcase
   end

   // jmp far / call far with 16-bit operand size: ptr16:16
   assign far16 = operand_override && (opcode == 16'h00EA || opcode == 16'h009A);

   // ptr16:32 otherwise, selector follows the 4-byte offset
   assign offset = far16 ? {off_win[31:16], 16'h0000, off_win[15:0]} : off_win[47:0];

endmodule

// ==== source/microcode_rom.sv ====
`timescale 1ns/10ps

module microcode_rom #(
   parameter int uaddr_bits = 8
) (
   input  logic [uaddr_bits-1:0]  control_address,
   input  logic                   opsize_sel,
   output decode2_pkg::ctrl_word_t control_word
);
   import decode2_pkg::*;

   ctrl_word_t cw;

   always_comb begin
      cw = '0;
      case (control_address)
         // alu reg/rm, alu op taken from modrm reg
         uaddr_bits'('h01): begin
            cw[cw_ld_gpr1] = 1'b1;
            // byte form of the opcode
            if (opsize_sel) begin
               cw[cw_mux_op_size]   = 1'b1;
               cw[cw_op_size +: 2] = size_8;
            end
         end
         // mov with fixed 32-bit size
         uaddr_bits'('h05): begin
            cw[cw_mux_op_size]   = 1'b1;
            cw[cw_op_size +: 2] = size_32;
            cw[cw_ld_gpr1]      = 1'b1;
         end
         // push-like, first of two uops
         uaddr_bits'('h10): begin
            cw[cw_uop_stall]                       = 1'b1;
            cw[cw_next_uaddr +: cw_next_uaddr_w] = 7'h40;
            cw[cw_mux_mem_rd]                      = 1'b1;
            cw[cw_mem_rd]                          = 1'b0;
         end
         // second uop, reads through esp
         uaddr_bits'('h40): begin
            cw[cw_mux_sr1]     = 1'b1;
            cw[cw_sr1 +: 3]    = 3'd4;
            cw[cw_mux_mem_rd]  = 1'b1;
            cw[cw_mem_rd]      = 1'b1;
         end
         // jmp
         uaddr_bits'('h20): begin
            cw[cw_jmp_stall] = 1'b1;
         end
         default: cw = '0;
      endcase
   end

   assign control_word = cw;

endmodule

// ==== source/operand_ctrl.sv ====
`timescale 1ns/10ps

module operand_ctrl (
   input  logic                    clk,
   input  logic                    rst_n,
   input  decode2_pkg::ctrl_word_t control_word,
   input  logic [15:0]             opcode,
   input  logic                    operand_override,
   input  logic                    segment_override,
   input  decode2_pkg::reg_id_t    seg_id,
   input  logic [7:0]              modrm,
   input  logic [7:0]              sib,
   input  logic                    modrm_present,
   input  logic                    sib_present,
   output decode2_pkg::size_t      sr1_size,
   output decode2_pkg::size_t      sr2_size,
   output decode2_pkg::size_t      dr1_size,
   output decode2_pkg::size_t      mem_size,
   output decode2_pkg::reg_id_t    sr1,
   output decode2_pkg::reg_id_t    sr2,
   output decode2_pkg::reg_id_t    sr3,
   output decode2_pkg::reg_id_t    sr4,
   output decode2_pkg::reg_id_t    seg1,
   output decode2_pkg::reg_id_t    seg2,
   output logic [2:0]              aluk,
   output logic                    mem_rd,
   output logic                    ld_gpr1,
   output logic                    base_reg_en,
   output logic [1:0]              sib_scale
);
   import decode2_pkg::*;

   logic [1:0] mod;
   reg_id_t    rm;
   reg_id_t    reg_op;
   logic       mem_opnd;
   size_t      base_size;
   reg_id_t    base_id;
   logic       ss_modrm;
   logic       ss_sib;
   logic       push_pop;

   assign mod    = modrm[7:6];
   assign rm     = modrm[2:0];
   assign reg_op = modrm[5:3];

   // memory operand whenever modrm is there and mod is not 11
   assign mem_opnd = modrm_present && (mod != 2'b11);

   always_comb begin
      if (control_word[cw_mux_op_size]) begin
         base_size = control_word[cw_op_size +: 2];
      end else begin
         base_size = operand_override ? size_16 : size_32;
      end
   end

   // address registers are always 32 bits wide
   assign sr1_size = mem_opnd ? size_32 : base_size;
   assign sr2_size = base_size;
   assign dr1_size = base_size;
   assign mem_size = base_size;

   assign base_id   = sib_present ? sib[2:0] : rm;
   assign sr1       = control_word[cw_mux_sr1] ? control_word[cw_sr1 +: 3] : base_id;
   assign sr2       = reg_op;
   assign sr3       = reg_op;
   assign sr4       = sib[5:3];
   assign sib_scale = sib[7:6];
   assign aluk      = control_word[cw_mux_aluk] ? control_word[cw_aluk +: 3] : reg_op;

   assign mem_rd  = control_word[cw_mux_mem_rd] ? control_word[cw_mem_rd] : mem_opnd;
   assign ld_gpr1 = control_word[cw_ld_gpr1] && !mem_opnd;

   // mod 00 rm 101 is disp32 with no base register
   assign base_reg_en = !(mod == 2'b00 && rm == 3'b101);

   // ebp or esp based addressing defaults to the stack segment
   assign ss_modrm = modrm_present && (mod == 2'b01 || mod == 2'b10) && rm == 3'b101;
   assign ss_sib   = sib_present && sib[2:0] == 3'b100;

   always_comb begin
      case (opcode)
         16'h0006, 16'h0007, 16'h000E,
         16'h0016, 16'h0017, 16'h001E, 16'h001F: push_pop = 1'b1;
         default:                                push_pop = 1'b0;
      endcase
   end

   always_comb begin
      if (segment_override) begin
         seg1 = seg_id;
      end else if (ss_modrm || ss_sib || push_pop) begin
         seg1 = seg_ss;
      end else begin
         seg1 = seg_ds;
      end
   end

   assign seg2 = reg_op;

   // a memory operand needs a full 32-bit address source, even for byte ops
   a_mem_sr1_size: assert property (
      @(posedge clk) disable iff (!rst_n)
      (modrm_present && modrm[7:6] != 2'b11) |-> sr1_size != size_8
   ) else $error("sr1_size is size_8 for a memory operand");

endmodule

// ==== source/uop_sequencer.sv ====
`timescale 1ns/10ps

module uop_sequencer (
   input  logic                                      clk,
   input  logic                                      rst_n,
   input  logic                                      d2_v,
   input  logic                                      ld_d2,
   input  logic                                      uop_stall_cw,
   input  logic [decode2_pkg::cw_next_uaddr_w-1:0]   next_uaddr,
   input  logic                                      int_exist,
   input  logic                                      repne_terminate,
   input  decode2_pkg::uaddr_t                       decode_address,
   input  logic                                      opcode_size,
   output decode2_pkg::uaddr_t                       control_address,
   output logic                                      opsize_sel
);
   import decode2_pkg::*;

   logic [cw_next_uaddr_w-1:0] next_q;
   logic                       sel_uop;
   logic                       cancel;

   // interrupt or repne termination drops the rest of the sequence
   assign cancel = int_exist || repne_terminate;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         next_q  <= '0;
         sel_uop <= 1'b0;
      end else begin
         if (d2_v && ld_d2) begin
            next_q <= next_uaddr;
         end
         sel_uop <= d2_v && uop_stall_cw && !cancel;
      end
   end

   // stored micro-address lives in the lower half of the store
   assign control_address = sel_uop ? uaddr_t'({1'b0, next_q}) : decode_address;
   assign opsize_sel      = sel_uop ? 1'b0 : opcode_size;

   // a follow-on uop only ever comes from a valid item the cycle before
   a_sel_after_valid: assert property (
      @(posedge clk) disable iff (!rst_n) sel_uop |-> $past(d2_v)
   ) else $error("sel_uop high without a valid item on the previous cycle");

endmodule

// ==== testbench/decode_stage2_tb.sv ====
`timescale 1ns/10ps

module decode_stage2_tb;

   localparam int n_tests = 22;

   // one table row: stimulus first, then the expected decode
   typedef struct packed {
      logic [7:0] uaddr;
      logic [5:0] flags;
      logic [2:0] exc;
      logic [2:0] seg_id;
      logic [7:0] opcode;
      logic [7:0] modrm;
      logic [7:0] sib;
      logic [1:0] e_sr1_size;
      logic [1:0] e_size;
      logic [2:0] e_sr1;
      logic [2:0] e_seg1;
      logic [4:0] e_flags;
      logic [7:0] e_next;
   } vec_t;

   // flags   = d2_v, int_exist, operand_override, segment_override, modrm_present, sib_present
   // exc     = nmi, general protection, page fault enables
   // e_flags = mem_rd, ld_gpr1, base_reg_en, uop_stall, jmp_stall
   // e_next  = control_address one cycle later
   // uaddr  flags     exc    seg   op    modrm sib    sr1sz sz   sr1  seg1 e_flags   e_next
   vec_t tbl [n_tests] = '{
      '{8'h01,6'b100010,3'b000,3'd0,8'h03,8'hC8,8'h00,  2'd2,2'd2,3'd0,3'd3,5'b01100,8'h01},
      '{8'h01,6'b100010,3'b100,3'd0,8'h01,8'hD3,8'h00,  2'd2,2'd2,3'd3,3'd3,5'b01100,8'h01},
      '{8'h00,6'b000010,3'b010,3'd0,8'h01,8'hC0,8'h00,  2'd2,2'd2,3'd0,3'd3,5'b00100,8'h00},
      '{8'h00,6'b100000,3'b001,3'd0,8'h01,8'h00,8'h00,  2'd2,2'd2,3'd0,3'd3,5'b00100,8'h00},
      '{8'h00,6'b101000,3'b000,3'd0,8'hEA,8'h00,8'h00,  2'd1,2'd1,3'd0,3'd3,5'b00100,8'h00},
      '{8'h00,6'b100000,3'b000,3'd0,8'hEA,8'h00,8'h00,  2'd2,2'd2,3'd0,3'd3,5'b00100,8'h00},
      '{8'h00,6'b101000,3'b000,3'd0,8'h9A,8'h00,8'h00,  2'd1,2'd1,3'd0,3'd3,5'b00100,8'h00},
      '{8'h10,6'b100010,3'b000,3'd0,8'hFF,8'hF1,8'h00,  2'd2,2'd2,3'd1,3'd3,5'b00110,8'h40},
      '{8'h10,6'b110010,3'b000,3'd0,8'hFF,8'hF1,8'h00,  2'd2,2'd2,3'd1,3'd3,5'b00100,8'h10},
      '{8'h01,6'b101010,3'b000,3'd0,8'h03,8'hC0,8'h00,  2'd1,2'd1,3'd0,3'd3,5'b01100,8'h01},
      '{8'h01,6'b101010,3'b000,3'd0,8'h03,8'h03,8'h00,  2'd2,2'd1,3'd3,3'd3,5'b10100,8'h01},
      '{8'h05,6'b101010,3'b000,3'd0,8'h8B,8'hC2,8'h00,  2'd2,2'd2,3'd2,3'd3,5'b01100,8'h05},
      '{8'h00,6'b100110,3'b000,3'd4,8'h8B,8'h45,8'h00,  2'd2,2'd2,3'd5,3'd4,5'b10100,8'h00},
      '{8'h00,6'b100010,3'b000,3'd0,8'h8B,8'h85,8'h00,  2'd2,2'd2,3'd5,3'd2,5'b10100,8'h00},
      '{8'h00,6'b100011,3'b000,3'd0,8'h8B,8'h04,8'h24,  2'd2,2'd2,3'd4,3'd2,5'b10100,8'h00},
      '{8'h00,6'b100000,3'b000,3'd0,8'h1E,8'h00,8'h00,  2'd2,2'd2,3'd0,3'd2,5'b00100,8'h00},
      '{8'h00,6'b100000,3'b000,3'd0,8'h07,8'h00,8'h00,  2'd2,2'd2,3'd0,3'd2,5'b00100,8'h00},
      '{8'h01,6'b100010,3'b000,3'd0,8'h03,8'h1D,8'h00,  2'd2,2'd2,3'd5,3'd3,5'b10000,8'h01},
      '{8'h01,6'b100011,3'b000,3'd0,8'h03,8'h0C,8'h9A,  2'd2,2'd2,3'd2,3'd3,5'b10100,8'h01},
      '{8'h20,6'b100000,3'b000,3'd0,8'hE9,8'h00,8'h00,  2'd2,2'd2,3'd0,3'd3,5'b00101,8'h20},
      '{8'h20,6'b000000,3'b000,3'd0,8'hE9,8'h00,8'h00,  2'd2,2'd2,3'd0,3'd3,5'b00100,8'h20},
      '{8'h01,6'b100010,3'b000,3'd0,8'h01,8'hF9,8'h00,  2'd2,2'd2,3'd1,3'd3,5'b01100,8'h01}
   };

   logic clk, rst_n, d2_v, ld_d2;
   logic [127:0] ir;
   logic [31:0] eip, eip_out, disp32, imm32;
   logic [15:0] cs, cs_out, opcode;
   logic [3:0] instr_length, disp_sel, imm_sel, off_sel;
   logic opcode_size, operand_override, segment_override, repeat_prefix;
   logic modrm_present, sib_present, disp_present, disp_size;
   logic [1:0] imm_size, offset_size, sr1_size, sr2_size, dr1_size, mem_size, sib_scale;
   logic [2:0] seg_id, sr1, sr2, sr3, sr4, seg1, seg2, aluk;
   logic [7:0] modrm, sib, decode_address, control_address;
   logic nmi_int_en, gen_prot_exc_en, page_fault_exc_en, int_exist, repne_terminate;
   logic [23:0] control_word;
   logic [47:0] offset;
   logic mem_rd, ld_gpr1, base_reg_en, sib_en, disp_en, repne, uop_stall, jmp_stall, exc_v;

   logic [31:0] rng = 32'd14;
   int errors = 0;
   int test_errors = 0;
   int passed = 0;
   int cur_test = 0;

   decode_stage2 #(
      .ir_bytes   (16),
      .uaddr_bits (8)
   ) i_decode_stage2 (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic logic [31:0] xorshift32();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   // little-endian value of nbytes bytes starting at byte pos
   function automatic logic [31:0] le_bytes(input logic [127:0] win, input int pos,
                                            input int nbytes);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < nbytes; i++) begin
         v[8*i +: 8] = win[8*(pos+i) +: 8];
      end
      return v;
   endfunction

   function automatic logic [31:0] sign_ext(input logic [31:0] v, input int nbytes);
      case (nbytes)
         1:       return {{24{v[7]}}, v[7:0]};
         2:       return {{16{v[15]}}, v[15:0]};
         default: return v;
      endcase
   endfunction

   // control store words with the byte form off, fields packed from bit 0 upward
   function automatic logic [23:0] cw_for_address(input logic [7:0] a);
      case (a)
         8'h01:   return 24'h008000;
         8'h05:   return 24'h008500;
         8'h10:   return 24'h010081;
         8'h40:   return 24'h034800;
         8'h20:   return 24'h400000;
         default: return 24'h000000;
      endcase
   endfunction

   task automatic expect_eq(input logic [47:0] got, input logic [47:0] want, input string what);
      assert (got === want) else begin
         $display("FAIL %0t: test %0d %s is %h, expected %h", $time, cur_test, what, got, want);
         test_errors++;
      end
   endtask

   task automatic drive_idle();
      {d2_v, ld_d2, ir, eip, cs, instr_length, opcode, opcode_size} = '0;
      {operand_override, segment_override, repeat_prefix, modrm_present} = '0;
      {sib_present, disp_present, disp_sel, disp_size, imm_sel, imm_size, off_sel} = '0;
      {offset_size, seg_id, modrm, sib, decode_address} = '0;
      {nmi_int_en, gen_prot_exc_en, page_fault_exc_en, int_exist, repne_terminate} = '0;
   endtask

   // drive one row on the falling edge, check now and one cycle later
   task automatic run_vector(input int t);
      vec_t v;
      int dsel, isel, osel, isz, nb;
      logic [31:0] r, e_eip, e_disp, e_imm, sel_part, off_part;
      logic far16, exc_any;
      logic [2:0] reg_f;
      v = tbl[t];
      cur_test = t;
      test_errors = 0;
      @(negedge clk);
      decode_address = v.uaddr;
      {d2_v, int_exist, operand_override, segment_override, modrm_present, sib_present} = v.flags;
      ld_d2 = v.flags[5];
      {nmi_int_en, gen_prot_exc_en, page_fault_exc_en} = v.exc;
      seg_id = v.seg_id;
      opcode = {8'h00, v.opcode};
      modrm = v.modrm;
      sib = v.sib;
      for (int w = 0; w < 4; w++) begin
         ir[32*w +: 32] = xorshift32();
      end
      eip = xorshift32();
      r = xorshift32();
      cs = r[15:0];
      repeat_prefix = r[16];
      disp_present = r[17];
      disp_size = r[18];
      instr_length = r[23:20];
      // positions kept inside the window
      dsel = xorshift32() % 13;
      isel = xorshift32() % 13;
      osel = xorshift32() % 11;
      isz = xorshift32() % 3;
      disp_sel = dsel[3:0];
      imm_sel = isel[3:0];
      off_sel = osel[3:0];
      imm_size = isz[1:0];

      nb = (isz == 0) ? 1 : (isz == 1) ? 2 : 4;
      far16 = operand_override && (v.opcode == 8'hEA || v.opcode == 8'h9A);
      e_disp = disp_size ? le_bytes(ir, dsel, 4) : sign_ext(le_bytes(ir, dsel, 1), 1);
      e_imm = sign_ext(le_bytes(ir, isel, nb), nb);
      sel_part = le_bytes(ir, far16 ? osel + 2 : osel + 4, 2);
      off_part = le_bytes(ir, osel, far16 ? 2 : 4);
      exc_any = |v.exc;
      e_eip = exc_any ? eip : eip + {28'd0, instr_length};
      reg_f = v.modrm[5:3];

      #2;
      expect_eq(48'(eip_out), 48'(e_eip), "eip_out");
      expect_eq(48'(exc_v), 48'(d2_v && exc_any), "exc_v");
      expect_eq(48'(control_address), 48'(v.uaddr), "control_address");
      expect_eq(48'(control_word), 48'(cw_for_address(v.uaddr)), "control_word");
      expect_eq(48'(disp32), 48'(e_disp), "disp32");
      expect_eq(48'(imm32), 48'(e_imm), "imm32");
      expect_eq(offset, {sel_part[15:0], off_part}, "offset");
      expect_eq(48'(sr1_size), 48'(v.e_sr1_size), "sr1_size");
      expect_eq(48'({sr2_size, dr1_size, mem_size}), 48'({3{v.e_size}}), "sr2/dr1/mem size");
      expect_eq(48'(sr1), 48'(v.e_sr1), "sr1");
      expect_eq(48'({sr2, sr3, aluk, seg2}), 48'({4{reg_f}}), "sr2/sr3/aluk/seg2");
      expect_eq(48'({sr4, sib_scale}), 48'({v.sib[5:3], v.sib[7:6]}), "sr4/sib_scale");
      expect_eq(48'(seg1), 48'(v.e_seg1), "seg1");
      expect_eq(48'({mem_rd, ld_gpr1, base_reg_en, uop_stall, jmp_stall}), 48'(v.e_flags),
                "mem_rd/ld_gpr1/base_reg_en/uop_stall/jmp_stall");
      expect_eq(48'({cs_out, repne, sib_en, disp_en}),
                48'({cs, repeat_prefix, sib_present, disp_present}), "pass-through");

      // upstream holds the item, sequencer state has moved by one edge
      @(negedge clk);
      #2;
      expect_eq(48'(control_address), 48'(v.e_next), "control_address next cycle");
      expect_eq(48'(control_word), 48'(cw_for_address(v.e_next)), "control_word next cycle");
      if (v.e_next == 8'h40) begin
         expect_eq(48'({mem_rd, sr1}), 48'({1'b1, 3'd4}), "second uop mem_rd/sr1");
      end

      if (test_errors == 0) begin
         passed++;
      end
      errors += test_errors;
      $display("test %2d done, %0d error(s)", t, test_errors);
   endtask

   initial begin
      drive_idle();
      rst_n = 1'b0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      for (int t = 0; t < n_tests; t++) begin
         run_vector(t);
      end
      $display("%0d tests, %0d passed, %0d failed, %0d check errors",
               n_tests, passed, n_tests - passed, errors);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   // watchdog, generous bound on the whole table
   initial begin
      repeat (n_tests * 20) @(posedge clk);
      $display("timeout: test loop did not finish within %0d cycles", n_tests * 20);
      $display("Simulation failed");
      $finish;
   end

endmodule
